/* gbt_link_top.f */
+incdir+logic
logic/gbt_link_pkg.sv
logic/gbt_frame_packer.sv
logic/elink_tap_delay.sv
logic/gbt_frame_deframer.sv
logic/ttc_decoder.sv
logic/gbt_link_top.sv
verification/gbt_link_tb.sv

/* Bender.yml */
package:
  name: gbt_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/gbt_link_pkg.sv
      - logic/gbt_frame_packer.sv
      - logic/elink_tap_delay.sv
      - logic/gbt_frame_deframer.sv
      - logic/ttc_decoder.sv
      - logic/gbt_link_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/gbt_link_tb.sv

/* verification/gbt_link_tb.sv */
`default_nettype none

`include "gbt_link_macros.svh"

module gbt_link_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import gbt_link_pkg::*;

  localparam int MAXC = 1024;  // expectation slots, one per cycle
  localparam int NTBL = 7;

  logic                          clk40 = 1'b0;
  logic                          arst_n_i;
  logic [`GBT_DLY_SELWIDTH-1:0]  sel_i;
  logic                          req_valid_i, wr_en_i;
  logic [31:0]                   addr_i, data_i;
  ttc_t                          ttc_i;
  logic                          req_valid_o, wr_en_o, drop_o;
  logic [31:0]                   addr_o, data_o;
  logic                          l1a_o, calpulse_o, resync_o, bc0_o;
  logic [`GBT_BXN_WIDTH-1:0]     bxn_o;

  // stimulus table, one row per test
  string       t_name [NTBL];
  int          t_sel  [NTBL];
  logic [31:0] t_mask [NTBL];  // bit c strobes a request in cycle c
  logic        t_wr   [NTBL];
  logic [31:0] t_addr [NTBL];
  logic [31:0] t_data [NTBL];
  logic [15:0] t_ttc  [NTBL];  // nibble c drives ttc in cycle c
  int          t_gap  [NTBL];
  int          n_tbl = 0;

  // reference model state
  logic [3:0]                exp_ttc  [MAXC];
  int                        ttc_tid  [MAXC];
  logic                      exp_drop [MAXC];
  int                        req_cyc_q [$];
  logic [64:0]               req_q [$];  // wr_en, addr, data
  string                     req_name_q [$];
  logic [`GBT_BXN_WIDTH-1:0] bxn_m = '0;
  int edge_cnt = 0;
  int run_limit = 200;
  int next_free = 0;  // first edge where the packer takes a new strobe
  int last_exp_cyc = 0;
  int cur_tid = 0;
  int seed = 10387;

  gbt_link_top u_dut (
    .clk40 (clk40), .arst_n_i (arst_n_i), .sel_i (sel_i),
    .req_valid_i (req_valid_i), .wr_en_i (wr_en_i), .addr_i (addr_i), .data_i (data_i),
    .ttc_i (ttc_i), .req_valid_o (req_valid_o), .wr_en_o (wr_en_o), .addr_o (addr_o),
    .data_o (data_o), .drop_o (drop_o), .l1a_o (l1a_o), .calpulse_o (calpulse_o),
    .resync_o (resync_o), .bc0_o (bc0_o), .bxn_o (bxn_o)
  );

  initial begin
    forever #4 clk40 = ~clk40;  // 125 MHz sim clock, period 8 ns
  end

  always @(posedge clk40)
    if (arst_n_i)
      edge_cnt <= edge_cnt + 1;  // edge 1 is the first after reset

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input string what,
                         input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v)
      report_failure($sformatf("mismatch %s %s expected %0h actual %0h",
                               name, what, exp_v, act_v));
  endtask

  task automatic add_entry(input string name, input int sel, input logic [31:0] mask,
                           input logic wr, input logic [31:0] addr, input logic [31:0] data,
                           input logic [15:0] ttc, input int gap);
    t_name[n_tbl] = name;
    t_sel[n_tbl]  = sel;
    t_mask[n_tbl] = mask;
    t_wr[n_tbl]   = wr;
    t_addr[n_tbl] = addr;
    t_data[n_tbl] = data;
    t_ttc[n_tbl]  = ttc;
    t_gap[n_tbl]  = gap;
    n_tbl++;
  endtask

  // --------------------
  // output checks, every cycle
  // --------------------

  always @(negedge clk40) begin : monitor
    string nm;
    if (edge_cnt > 0) begin
      if (edge_cnt >= run_limit)
        report_failure($sformatf("run did not finish within %0d cycles", run_limit));
      nm = t_name[ttc_tid[edge_cnt]];
      compare(nm, "ttc strobes", exp_ttc[edge_cnt], {l1a_o, calpulse_o, resync_o, bc0_o});
      bxn_m = exp_ttc[edge_cnt-1][0] ? '0 : bxn_m + 1'b1;  // bc0 strobe one cycle back
      compare(nm, "bxn", bxn_m, bxn_o);
      compare(t_name[cur_tid], "drop", exp_drop[edge_cnt], drop_o);
      if (req_cyc_q.size() != 0 && req_cyc_q[0] == edge_cnt) begin
        compare(req_name_q[0], "req_valid", 1, req_valid_o);
        compare(req_name_q[0], "wr_en", req_q[0][64], wr_en_o);
        compare(req_name_q[0], "addr", req_q[0][63:32], addr_o);
        compare(req_name_q[0], "data", req_q[0][31:0], data_o);
        void'(req_cyc_q.pop_front());
        void'(req_q.pop_front());
        void'(req_name_q.pop_front());
      end else if (req_valid_o !== 1'b0) begin
        report_failure($sformatf("req_valid_o high in cycle %0d with no request due", edge_cnt));
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------

  initial begin : stimulus
    int i;
    int c;
    int e;
    int nstb;
    int t;
    logic [3:0] ttc_w;
    logic [31:0] rnd;

    arst_n_i    = 1'b0;
    sel_i       = '0;
    req_valid_i = 1'b0;
    wr_en_i     = 1'b0;
    addr_i      = '0;
    data_i      = '0;
    ttc_i       = '0;
    for (i = 0; i < MAXC; i++) begin
      exp_ttc[i]  = '0;
      ttc_tid[i]  = 0;
      exp_drop[i] = 1'b0;
    end

    //        name              sel mask          wr    addr          data          ttc      gap
    add_entry("reset_idle",      0, 32'h0,        1'b0, 32'h0,        32'h0,        16'h0,    4);
    add_entry("single_sel0",     0, 32'h1,        1'b1, 32'h8000_1234, 32'hDEAD_BEEF, 16'h0081, 20);
    add_entry("ttc_sel0",        0, 32'h0,        1'b0, 32'h0,        32'h0,        16'h6F42, 50);
    add_entry("single_sel7",     7, 32'h1,        1'b0, 32'h0000_00FC, 32'h0000_0001, 16'h1009, 50);
    add_entry("back2back_sel7",  7, 32'h0100_1001, 1'b1, 32'hFFFF_FFFF, 32'h5555_AAAA, 16'h8421, 80);
    add_entry("drop_busy_sel31", 31, 32'h0000_1821, 1'b1, 32'h1234_5678, 32'h9ABC_DEF0, 16'h0101, 60);
    add_entry("single_sel31",    31, 32'h1,        1'b0, 32'hA5A5_5A5A, 32'h0F0F_F0F0, 16'hA5F0, 50);
    for (i = 0; i < NTBL; i++)
      run_limit += t_gap[i];

    repeat (5) @(negedge clk40);
    compare("reset", "req_valid", 0, req_valid_o);  // still held in reset
    compare("reset", "drop", 0, drop_o);
    compare("reset", "ttc strobes", 0, {l1a_o, calpulse_o, resync_o, bc0_o});
    compare("reset", "bxn", 0, bxn_o);
    arst_n_i = 1'b1;

    for (i = 0; i < NTBL; i++) begin
      cur_tid = i;
      nstb    = 0;
      for (c = 0; c < t_gap[i]; c++) begin
        e     = edge_cnt + 1;  // edge that samples what is driven now
        t     = e + 3 + t_sel[i];
        sel_i = t_sel[i];
        ttc_w = (c < 4) ? t_ttc[i][4*c +: 4] : 4'h0;
        ttc_i = ttc_w;
        exp_ttc[t] = ttc_w;
        ttc_tid[t] = i;
        if (t > last_exp_cyc)
          last_exp_cyc = t;
        req_valid_i = (c < 32) ? t_mask[i][c] : 1'b0;
        wr_en_i = 1'b0;
        addr_i  = '0;
        data_i  = '0;
        if (req_valid_i) begin
          if (nstb == 0) begin
            wr_en_i = t_wr[i];
            addr_i  = t_addr[i];
            data_i  = t_data[i];
          end else begin  // later strobes of a row are random
            addr_i  = $random(seed);
            data_i  = $random(seed);
            rnd     = $random(seed);
            wr_en_i = rnd[31];
          end
          nstb++;
          if (e >= next_free) begin
            req_cyc_q.push_back(e + 14 + t_sel[i]);
            req_q.push_back({wr_en_i, addr_i, data_i});
            req_name_q.push_back(t_name[i]);
            next_free = e + 12;  // busy through e+11
            if (e + 14 + t_sel[i] > last_exp_cyc)
              last_exp_cyc = e + 14 + t_sel[i];
          end else begin
            exp_drop[e] = 1'b1;  // lands in the busy window
          end
        end
        @(negedge clk40);
      end
    end

    req_valid_i = 1'b0;
    wr_en_i     = 1'b0;
    addr_i      = '0;
    data_i      = '0;
    ttc_i       = '0;
    // drain the link, the monitor stops a hang
    while (req_cyc_q.size() != 0 || edge_cnt <= last_exp_cyc)
      @(negedge clk40);
    @(posedge clk40);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/gbt_link_top.sv */
`default_nettype none

`include "gbt_link_macros.svh"

module gbt_link_top (
  input  wire                            clk40,
  input  wire                            arst_n_i,
  input  wire  [`GBT_DLY_SELWIDTH-1:0]   sel_i,
  input  wire                            req_valid_i,
  input  wire                            wr_en_i,
  input  wire  [31:0]                    addr_i,
  input  wire  [31:0]                    data_i,
  input  wire  gbt_link_pkg::ttc_t       ttc_i,
  output logic                           req_valid_o,
  output logic                           wr_en_o,
  output logic [31:0]                    addr_o,
  output logic [31:0]                    data_o,
  output logic                           drop_o,
  output logic                           l1a_o,
  output logic                           calpulse_o,
  output logic                           resync_o,
  output logic                           bc0_o,
  output logic [`GBT_BXN_WIDTH-1:0]      bxn_o
);

  import gbt_link_pkg::*;

  gbt_frame_t tx_frame;   // packer out
  gbt_frame_t dly_frame;  // after link latency

  // --------------------
  // tx side
  // --------------------

  gbt_frame_packer u_packer (
    .clk40       (clk40),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .wr_en_i     (wr_en_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .ttc_i       (ttc_i),
    .frame_o     (tx_frame),
    .drop_o      (drop_o)
  );

  elink_tap_delay #(
    .SELWIDTH (`GBT_DLY_SELWIDTH)
  ) u_delay (
    .clk40    (clk40),
    .arst_n_i (arst_n_i),
    .sel_i    (sel_i),
    .frame_i  (tx_frame),
    .frame_o  (dly_frame)
  );

  // --------------------
  // rx side
  // --------------------

  gbt_frame_deframer u_deframer (
    .clk40       (clk40),
    .arst_n_i    (arst_n_i),
    .frame_i     (dly_frame),
    .req_valid_o (req_valid_o),
    .wr_en_o     (wr_en_o),
    .addr_o      (addr_o),
    .data_o      (data_o)
  );

  ttc_decoder u_ttc (
    .clk40      (clk40),
    .arst_n_i   (arst_n_i),
    .ttc_i      (dly_frame.ttc),  // payload ignored here
    .l1a_o      (l1a_o),
    .calpulse_o (calpulse_o),
    .resync_o   (resync_o),
    .bc0_o      (bc0_o),
    .bxn_o      (bxn_o)
  );

endmodule

`default_nettype wire

/* logic/ttc_decoder.sv */
`default_nettype none

`include "gbt_link_macros.svh"

module ttc_decoder (
  input  wire                           clk40,
  input  wire                           arst_n_i,
  input  wire  gbt_link_pkg::ttc_t      ttc_i,
  output logic                          l1a_o,
  output logic                          calpulse_o,
  output logic                          resync_o,
  output logic                          bc0_o,
  output logic [`GBT_BXN_WIDTH-1:0]     bxn_o   // bunch crossing number
);

  import gbt_link_pkg::*;

  ttc_t ttc_q;  // one frame of ttc bits

  // --------------------
  // strobes and bxn
  // --------------------

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ttc_q <= '0;
      bxn_o <= '0;
    end else begin
      ttc_q <= ttc_i;
      if (ttc_q.bc0)
        bxn_o <= '0;         // orbit start
      else
        bxn_o <= bxn_o + 1'b1;  // wraps at full width
    end
  end

  assign l1a_o      = ttc_q.l1a;
  assign calpulse_o = ttc_q.calpulse;
  assign resync_o   = ttc_q.resync;
  assign bc0_o      = ttc_q.bc0;

endmodule

`default_nettype wire

/* logic/gbt_frame_deframer.sv */
`default_nettype none

`include "gbt_link_macros.svh"

module gbt_frame_deframer (
  input  wire                             clk40,
  input  wire                             arst_n_i,
  input  wire  gbt_link_pkg::gbt_frame_t  frame_i,
  output logic                            req_valid_o,  // one-cycle strobe
  output logic                            wr_en_o,
  output logic [31:0]                     addr_o,
  output logic [31:0]                     data_o
);

  import gbt_link_pkg::*;

  localparam int NPAY = `GBT_FRAMES_PER_REQ - 1;  // payloads after start
  localparam int CNTW = $clog2(NPAY);
  localparam logic [CNTW-1:0] LAST_CNT = CNTW'(NPAY - 1);

  logic                 hunt_q;  // waiting for frame start
  logic [CNTW-1:0]      cnt_q;   // payloads collected so far
  payload_t [NPAY-1:0]  shift_q; // 66 bits, frame 1 ends up on top
  logic [NPAY*`GBT_PAYLOAD_WIDTH-1:0] req_bits_w;  // shift_q as one flat vector

  // --------------------
  // hunt / collect
  // --------------------

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hunt_q      <= 1'b1;
      cnt_q       <= '0;
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= 1'b0;
      if (hunt_q) begin
        if (frame_i.payload == `GBT_FRAME_START) begin
          hunt_q <= 1'b0;
          cnt_q  <= '0;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LAST_CNT) begin
          hunt_q      <= 1'b1;  // request complete, look for next start
          req_valid_o <= 1'b1;
        end
      end
    end
  end

  // payload only, frozen while hunting so fields hold after the strobe
  always_ff @(posedge clk40) begin
    if (!hunt_q)
      shift_q <= {shift_q[NPAY-2:0], frame_i.payload};
  end

  // --------------------
  // request fields
  // --------------------

  assign req_bits_w = shift_q;

  // bit 64 is the reserved zero from frame 1
  assign wr_en_o = shift_q[NPAY-1][5];
  assign addr_o  = req_bits_w[63:32];
  assign data_o  = req_bits_w[31:0];

  // a request always spans more than one frame
  a_single_strobe : assert property (@(posedge clk40) disable iff (!arst_n_i)
    req_valid_o |=> !req_valid_o);

endmodule

`default_nettype wire

/* logic/elink_tap_delay.sv */
`default_nettype none

`include "gbt_link_macros.svh"

module elink_tap_delay #(
  parameter int unsigned SELWIDTH = `GBT_DLY_SELWIDTH
) (
  input  wire                              clk40,
  input  wire                              arst_n_i,
  input  wire  [SELWIDTH-1:0]              sel_i,    // keep static while in use
  input  wire  gbt_link_pkg::gbt_frame_t   frame_i,
  output gbt_link_pkg::gbt_frame_t         frame_o
);

  localparam int DEPTH = 2**SELWIDTH;

  // tap 0 is the input itself, taps 1..DEPTH-1 come from here
  gbt_link_pkg::gbt_frame_t sr_q [DEPTH-1];

  // --------------------
  // shift and tap
  // --------------------

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH-1; i++)
        sr_q[i] <= '0;  // idle frames
      frame_o <= '0;
    end else begin
      sr_q[0] <= frame_i;
      for (int i = 1; i < DEPTH-1; i++)
        sr_q[i] <= sr_q[i-1];
      if (sel_i == '0)
        frame_o <= frame_i;  // one cycle, output register only
      else
        frame_o <= sr_q[sel_i - 1'b1];
    end
  end

  a_out_known : assert property (@(posedge clk40) disable iff (!arst_n_i)
    !$isunknown(frame_o));

endmodule

`default_nettype wire

/* logic/gbt_frame_packer.sv */
`default_nettype none

`include "gbt_link_macros.svh"

module gbt_frame_packer (
  input  wire                       clk40,
  input  wire                       arst_n_i,
  input  wire                       req_valid_i,  // single-cycle strobe
  input  wire                       wr_en_i,
  input  wire  [31:0]               addr_i,
  input  wire  [31:0]               data_i,
  input  wire  gbt_link_pkg::ttc_t  ttc_i,
  output gbt_link_pkg::gbt_frame_t  frame_o,
  output logic                      drop_o        // strobe lost while busy
);

  import gbt_link_pkg::*;

  localparam int IDXW = $clog2(`GBT_FRAMES_PER_REQ);
  localparam logic [IDXW-1:0] LAST_IDX = IDXW'(`GBT_FRAMES_PER_REQ - 1);

  logic            active_q;  // frames of a request going out
  logic [IDXW-1:0] idx_q;     // frame being built next
  logic            busy_w;
  logic            accept_w;

  logic            wr_en_q;
  logic [31:0]     addr_q;
  logic [31:0]     data_q;
  ttc_t            ttc_q;
  payload_t        payload_w;

  // --------------------
  // frame sequencing
  // --------------------

  // last frame still allows a new strobe, back-to-back at 12 cycles
  assign busy_w   = active_q && (idx_q != LAST_IDX);
  assign accept_w = req_valid_i && !busy_w;

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      idx_q    <= '0;
      drop_o   <= 1'b0;
    end else begin
      drop_o <= req_valid_i && busy_w;
      if (accept_w) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (active_q) begin
        if (idx_q == LAST_IDX)
          active_q <= 1'b0;  // back to idle frames
        else
          idx_q <= idx_q + 1'b1;
      end
    end
  end

  // request held for the whole burst
  always_ff @(posedge clk40) begin
    if (accept_w) begin
      wr_en_q <= wr_en_i;
      addr_q  <= addr_i;
      data_q  <= data_i;
    end
  end

  // --------------------
  // payload select
  // --------------------

  always_comb begin
    payload_w = '0;  // idle
    if (active_q) begin
      case (idx_q)
        4'd0:    payload_w = `GBT_FRAME_START;
        4'd1:    payload_w = {wr_en_q, 1'b0, addr_q[31:28]};  // bit 4 reserved
        4'd2:    payload_w = addr_q[27:22];
        4'd3:    payload_w = addr_q[21:16];
        4'd4:    payload_w = addr_q[15:10];
        4'd5:    payload_w = addr_q[9:4];
        4'd6:    payload_w = {addr_q[3:0], data_q[31:30]};  // addr/data split
        4'd7:    payload_w = data_q[29:24];
        4'd8:    payload_w = data_q[23:18];
        4'd9:    payload_w = data_q[17:12];
        4'd10:   payload_w = data_q[11:6];
        4'd11:   payload_w = data_q[5:0];
        default: payload_w = '0;
      endcase
    end
  end

  // ttc takes one stage, same as the request latch
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ttc_q   <= '0;
      frame_o <= '0;
    end else begin
      ttc_q           <= ttc_i;
      frame_o.ttc     <= ttc_q;
      frame_o.payload <= payload_w;
    end
  end

  // index stays inside the frame table
  a_idx_range : assert property (@(posedge clk40) disable iff (!arst_n_i)
    active_q |-> idx_q <= LAST_IDX);

endmodule

`default_nettype wire

/* logic/gbt_link_pkg.sv */
`default_nettype none

`include "gbt_link_macros.svh"

package gbt_link_pkg;

  // ttc bits, same order as on the elink
  typedef struct packed {
    logic l1a;
    logic calpulse;
    logic resync;
    logic bc0;
  } ttc_t;

  // slow-control slice of one frame
  typedef logic [`GBT_PAYLOAD_WIDTH-1:0] payload_t;

  // one 10-bit elink frame, ttc on top
  typedef struct packed {
    ttc_t     ttc;
    payload_t payload;
  } gbt_frame_t;

endpackage

`default_nettype wire

/* logic/gbt_link_macros.svh */
`ifndef GBT_LINK_MACROS_SVH
`define GBT_LINK_MACROS_SVH

// --------------------
// elink frame format
// --------------------

`define GBT_PAYLOAD_WIDTH   6      // slow-control bits per frame
`define GBT_FRAME_START     6'h2A  // first frame of every request
`define GBT_FRAMES_PER_REQ  12     // start + 66 request bits / 6

// --------------------
// link and ttc
// --------------------

`define GBT_DLY_SELWIDTH    5      // 32 taps
`define GBT_BXN_WIDTH       12     // bunch crossing counter

`endif
